//--- design/umode_pkg.sv
/*
 * Shared types and constants of the user-mode privilege monitor.
 * Holds the mode, instruction class and rule code enums, the misa,
 * mstatus and dcsr bit positions, exception causes and the SYSTEM
 * instruction encodings. Refer to these with umode_pkg:: scoped names.
 */
`default_nettype none

package umode_pkg;

  localparam int NUM_RULES = 17;
  localparam int XLEN      = 32;
  localparam int CAUSE_W   = 6;

  typedef enum logic [1:0] {
    MODE_U = 2'd0,
    MODE_M = 2'd3
  } priv_mode_e;

  typedef enum logic [2:0] {
    INSN_OTHER,
    INSN_MRET,
    INSN_DRET,
    INSN_WFI,
    INSN_ECALL,
    INSN_EBREAK,
    INSN_URET,
    INSN_CSR
  } insn_class_e;

  // codes 0 to 11 are per retirement, 12 to 16 span two retirements
  typedef enum logic [4:0] {
    RULE_MISA,
    RULE_MODE_SUPPORTED,
    RULE_MPP_LEGAL,
    RULE_SPP_ZERO,
    RULE_UMODE_MPRV,
    RULE_DMODE_MMODE,
    RULE_EXT_BITS,
    RULE_MRET_MPRV,
    RULE_WFI_TW,
    RULE_URET,
    RULE_ECALL,
    RULE_UCSR_ACCESS,
    RULE_RESET_MMODE,
    RULE_TRAP_MMODE,
    RULE_MRET_RESUME,
    RULE_DRET_RESUME,
    RULE_EBREAKU
  } rule_e;

  localparam int MISA_U_POS = 20;
  localparam int MISA_S_POS = 18;
  localparam int MISA_N_POS = 13;

  // mstatus fields
  localparam int MPP_POS  = 11;
  localparam int SPP_POS  = 8;
  localparam int MPRV_POS = 17;
  localparam int TW_POS   = 21;
  localparam int XS_POS   = 15;
  localparam int FS_POS   = 13;
  localparam int SD_POS   = 31;

  // dcsr fields
  localparam int PRV_POS     = 0;
  localparam int EBREAKU_POS = 12;

  localparam logic [CAUSE_W-1:0] EXC_INSTR_FAULT     = 6'd1;
  localparam logic [CAUSE_W-1:0] EXC_ILLEGAL         = 6'd2;
  localparam logic [CAUSE_W-1:0] EXC_BREAKPOINT      = 6'd3;
  localparam logic [CAUSE_W-1:0] EXC_ECALL_U         = 6'd8;
  localparam logic [CAUSE_W-1:0] EXC_INSTR_BUS       = 6'd24;
  localparam logic [CAUSE_W-1:0] EXC_INSTR_INTEGRITY = 6'd25;

  localparam logic [XLEN-1:0] MRET_INSN   = 32'h3020_0073;
  localparam logic [XLEN-1:0] DRET_INSN   = 32'h7b20_0073;
  localparam logic [XLEN-1:0] WFI_INSN    = 32'h1050_0073;
  localparam logic [XLEN-1:0] ECALL_INSN  = 32'h0000_0073;
  localparam logic [XLEN-1:0] EBREAK_INSN = 32'h0010_0073;
  localparam logic [XLEN-1:0] URET_INSN   = 32'h0020_0073;
  localparam logic [6:0]      SYSTEM_OPCODE = 7'b1110011;

endpackage

`default_nettype wire

//--- design/insn_classifier.sv
/*
 * Classifies the retired instruction of the current trace beat.
 * Revoked (fetch fault) and trigger-hit instructions count as INSN_OTHER.
 * Also flags an illegal-instruction exception and the exceptions that
 * take priority over it.
 */
`default_nettype none

module insn_classifier (
  input  logic                          rvfi_valid,
  input  logic [umode_pkg::XLEN-1:0]    rvfi_insn,
  input  logic                          trap_valid,
  input  logic                          trap_exception,
  input  logic                          trap_debug,
  input  logic [umode_pkg::CAUSE_W-1:0] exc_cause,
  output umode_pkg::insn_class_e        insn_class,
  output logic                          illegal_insn,
  output logic                          higher_exc
);

  logic revoked;
  logic triggered;
  logic is_csr;

  assign revoked = trap_exception &&
                   (exc_cause inside {umode_pkg::EXC_INSTR_FAULT, umode_pkg::EXC_INSTR_BUS});

  // debug entry from ebreak with ebreaku is no trigger
  assign triggered = trap_valid && trap_debug && !trap_exception &&
                     (rvfi_insn != umode_pkg::EBREAK_INSN);

  assign is_csr = (rvfi_insn[6:0] == umode_pkg::SYSTEM_OPCODE) &&
                  (rvfi_insn[14:12] != 3'd0) && (rvfi_insn[14:12] != 3'd4);

  assign illegal_insn = trap_valid && trap_exception && (exc_cause == umode_pkg::EXC_ILLEGAL);

  assign higher_exc = trap_exception &&
                      (exc_cause inside {umode_pkg::EXC_INSTR_FAULT, umode_pkg::EXC_INSTR_BUS,
                                         umode_pkg::EXC_INSTR_INTEGRITY});

  always_comb begin
    insn_class = umode_pkg::INSN_OTHER;
    if (rvfi_valid && !revoked && !triggered) begin
      case (rvfi_insn)
        umode_pkg::MRET_INSN:   insn_class = umode_pkg::INSN_MRET;
        umode_pkg::DRET_INSN:   insn_class = umode_pkg::INSN_DRET;
        umode_pkg::WFI_INSN:    insn_class = umode_pkg::INSN_WFI;
        umode_pkg::ECALL_INSN:  insn_class = umode_pkg::INSN_ECALL;
        umode_pkg::EBREAK_INSN: insn_class = umode_pkg::INSN_EBREAK;
        umode_pkg::URET_INSN:   insn_class = umode_pkg::INSN_URET;
        default: begin
          if (is_csr) begin
            insn_class = umode_pkg::INSN_CSR;
          end
        end
      endcase
    end
  end

endmodule

`default_nettype wire

//--- design/mode_tracker.sv
/*
 * Keeps the facts of the last retirement for the two-retirement rules.
 * Updates on every rvfi_valid beat and holds otherwise. Predicts the
 * mode the next retirement should run in.
 */
`default_nettype none

module mode_tracker (
  input  logic                       clk_i,
  input  logic                       rst_n,
  input  logic                       rvfi_valid,
  input  umode_pkg::priv_mode_e      rvfi_mode,
  input  logic                       rvfi_dbg_mode,
  input  logic                       trap_valid,
  input  logic                       trap_exception,
  input  umode_pkg::insn_class_e     insn_class,
  input  logic [umode_pkg::XLEN-1:0] mstatus_rdata,
  input  logic [umode_pkg::XLEN-1:0] dcsr_rdata,
  output logic                       prev_valid,
  output logic                       first_after_reset,
  output umode_pkg::insn_class_e     prev_class,
  output logic                       prev_trap,
  output logic                       prev_dbg_mode,
  output logic                       prev_ebreaku,
  output umode_pkg::priv_mode_e      prev_mode,
  output umode_pkg::priv_mode_e      expected_mode
);

  typedef enum logic {
    TRK_RESET,
    TRK_RUN
  } trk_state_e;

  trk_state_e            state;
  umode_pkg::priv_mode_e next_mode;

  // dcsr.prv also governs the exit from any debug-mode retirement
  always_comb begin
    if ((insn_class == umode_pkg::INSN_MRET) && !trap_exception) begin
      next_mode = umode_pkg::priv_mode_e'(mstatus_rdata[umode_pkg::MPP_POS +: 2]);
    end else if (((insn_class == umode_pkg::INSN_DRET) || rvfi_dbg_mode) && !trap_exception) begin
      next_mode = umode_pkg::priv_mode_e'(dcsr_rdata[umode_pkg::PRV_POS +: 2]);
    end else if (trap_valid) begin
      next_mode = umode_pkg::MODE_M;
    end else begin
      next_mode = rvfi_mode;
    end
  end

  always_ff @(posedge clk_i or negedge rst_n) begin
    if (!rst_n) begin
      state <= TRK_RESET;
    end else if (rvfi_valid) begin
      state <= TRK_RUN;
    end
  end

  always_ff @(posedge clk_i) begin
    if (rvfi_valid) begin
      prev_class    <= insn_class;
      prev_trap     <= trap_valid;
      prev_dbg_mode <= rvfi_dbg_mode;
      prev_ebreaku  <= dcsr_rdata[umode_pkg::EBREAKU_POS];
      prev_mode     <= rvfi_mode;
      expected_mode <= next_mode;
    end
  end

  assign prev_valid        = (state == TRK_RUN);
  assign first_after_reset = (state == TRK_RESET);

endmodule

`default_nettype wire

//--- design/static_rules.sv
/*
 * Per-retirement privilege checks, combinational.
 * Bit i of static_hit is rule code i (RULE_MISA up to RULE_UCSR_ACCESS)
 * and is only set in a cycle with rvfi_valid.
 */
`default_nettype none

module static_rules (
  input  logic                          rvfi_valid,
  input  umode_pkg::priv_mode_e         rvfi_mode,
  input  logic                          rvfi_dbg_mode,
  input  logic                          trap_valid,
  input  logic                          trap_exception,
  input  logic [umode_pkg::CAUSE_W-1:0] exc_cause,
  input  umode_pkg::insn_class_e        insn_class,
  input  logic                          illegal_insn,
  input  logic                          higher_exc,
  input  logic [umode_pkg::XLEN-1:0]    rvfi_insn,
  input  logic [umode_pkg::XLEN-1:0]    mstatus_rdata,
  input  logic [umode_pkg::XLEN-1:0]    mstatus_wdata,
  input  logic [umode_pkg::XLEN-1:0]    mstatus_wmask,
  input  logic [umode_pkg::XLEN-1:0]    misa_rdata,
  output logic [11:0]                   static_hit
);

  logic [umode_pkg::XLEN-1:0] mstatus_post;
  logic [1:0]                 mpp_post;
  logic                       in_umode;
  logic                       legal_trap;
  logic                       ecall_ok;
  logic                       mret_to_u;

  assign mstatus_post = (mstatus_wdata & mstatus_wmask) | (mstatus_rdata & ~mstatus_wmask);
  assign mpp_post     = mstatus_post[umode_pkg::MPP_POS +: 2];
  assign in_umode     = (rvfi_mode == umode_pkg::MODE_U);

  // exactly one of illegal or a higher priority fault
  assign legal_trap = illegal_insn ^ higher_exc;

  assign ecall_ok = trap_valid && trap_exception &&
                    (exc_cause inside {umode_pkg::EXC_ECALL_U, umode_pkg::EXC_INSTR_FAULT,
                                       umode_pkg::EXC_ILLEGAL, umode_pkg::EXC_INSTR_BUS,
                                       umode_pkg::EXC_INSTR_INTEGRITY});

  assign mret_to_u = (insn_class == umode_pkg::INSN_MRET) && !trap_valid &&
                     (mstatus_rdata[umode_pkg::MPP_POS +: 2] != umode_pkg::MODE_M);

  always_comb begin
    static_hit = '0;
    if (rvfi_valid) begin
      static_hit[0] = !misa_rdata[umode_pkg::MISA_U_POS] || misa_rdata[umode_pkg::MISA_S_POS] ||
                      misa_rdata[umode_pkg::MISA_N_POS];
      static_hit[1] = !(rvfi_mode inside {umode_pkg::MODE_U, umode_pkg::MODE_M});
      static_hit[2] = !(mpp_post inside {umode_pkg::MODE_U, umode_pkg::MODE_M});
      static_hit[3] = mstatus_rdata[umode_pkg::SPP_POS];
      static_hit[4] = in_umode && mstatus_rdata[umode_pkg::MPRV_POS];
      static_hit[5] = rvfi_dbg_mode && (rvfi_mode != umode_pkg::MODE_M);
      static_hit[6] = (mstatus_rdata[umode_pkg::XS_POS +: 2] != 2'b00) ||
                      (mstatus_rdata[umode_pkg::FS_POS +: 2] != 2'b00) ||
                      mstatus_rdata[umode_pkg::SD_POS];
      // mprv must be written, and written as zero
      static_hit[7] = mret_to_u && (!mstatus_wmask[umode_pkg::MPRV_POS] ||
                                    mstatus_wdata[umode_pkg::MPRV_POS]);
      static_hit[8] = in_umode && (insn_class == umode_pkg::INSN_WFI) &&
                      mstatus_rdata[umode_pkg::TW_POS] && !legal_trap;
      static_hit[9] = in_umode && (insn_class == umode_pkg::INSN_URET) && !legal_trap;
      static_hit[10] = in_umode && (insn_class == umode_pkg::INSN_ECALL) && !ecall_ok;
      // csr address bits 29:28 give the lowest privilege allowed
      static_hit[11] = in_umode && (insn_class == umode_pkg::INSN_CSR) &&
                       (rvfi_insn[29:28] != 2'b00) && !legal_trap;
    end
  end

endmodule

`default_nettype wire

//--- design/sequence_rules.sv
/*
 * Checks that relate the current retirement to the previous one.
 * seq_hit bit 0 is RULE_RESET_MMODE, bit 4 is RULE_EBREAKU.
 * Previous-retirement facts come from mode_tracker.
 */
`default_nettype none

module sequence_rules (
  input  logic                   rvfi_valid,
  input  umode_pkg::priv_mode_e  rvfi_mode,
  input  logic                   rvfi_dbg_mode,
  input  logic                   intr_valid,
  input  logic                   first_after_reset,
  input  logic                   prev_valid,
  input  umode_pkg::insn_class_e prev_class,
  input  logic                   prev_trap,
  input  logic                   prev_dbg_mode,
  input  logic                   prev_ebreaku,
  input  umode_pkg::priv_mode_e  prev_mode,
  input  umode_pkg::priv_mode_e  expected_mode,
  output logic [4:0]             seq_hit
);

  logic follows;
  logic off_expected;

  assign follows      = rvfi_valid && prev_valid;
  assign off_expected = (rvfi_mode != expected_mode) && !intr_valid;

  always_comb begin
    seq_hit = '0;
    seq_hit[0] = rvfi_valid && first_after_reset && (rvfi_mode != umode_pkg::MODE_M);
    if (follows) begin
      seq_hit[1] = prev_trap && (rvfi_mode != umode_pkg::MODE_M);
      // mret resume, only outside debug on both sides
      seq_hit[2] = (prev_class == umode_pkg::INSN_MRET) && !prev_trap && !prev_dbg_mode &&
                   !rvfi_dbg_mode && off_expected;
      // leaving debug mode
      seq_hit[3] = prev_dbg_mode && !rvfi_dbg_mode && off_expected;
      seq_hit[4] = (prev_class == umode_pkg::INSN_EBREAK) &&
                   (prev_mode == umode_pkg::MODE_U) && prev_ebreaku && !rvfi_dbg_mode;
    end
  end

endmodule

`default_nettype wire

//--- design/violation_reporter.sv
/*
 * Registers the combined rule hits into one-cycle violation pulses.
 * Holds a sticky flag and the lowest rule code of the first violating
 * retirement, both until reset.
 */
`default_nettype none

module violation_reporter (
  input  logic                            clk_i,
  input  logic                            rst_n,
  input  logic [umode_pkg::NUM_RULES-1:0] rule_hit,
  output logic [umode_pkg::NUM_RULES-1:0] violation,
  output logic                            violation_seen,
  output umode_pkg::rule_e                first_rule
);

  umode_pkg::rule_e lowest_rule;

  // scan down so the lowest set index wins
  always_comb begin
    lowest_rule = umode_pkg::RULE_MISA;
    for (int i = umode_pkg::NUM_RULES - 1; i >= 0; i--) begin
      if (rule_hit[i]) begin
        lowest_rule = umode_pkg::rule_e'(i[4:0]);
      end
    end
  end

  always_ff @(posedge clk_i or negedge rst_n) begin
    if (!rst_n) begin
      violation      <= '0;
      violation_seen <= 1'b0;
      first_rule     <= umode_pkg::RULE_MISA;
    end else begin
      violation <= rule_hit;
      if (|rule_hit) begin
        violation_seen <= 1'b1;
        if (!violation_seen) begin
          first_rule <= lowest_rule;
        end
      end
    end
  end

endmodule

`default_nettype wire

//--- design/umode_monitor.sv
/*
 * Top of the user-mode privilege monitor.
 * Feed one retirement trace beat per rvfi_valid cycle. A broken rule
 * shows as a one-cycle pulse on its violation bit in the next cycle,
 * together with violation_seen and first_rule.
 */
`default_nettype none

module umode_monitor (
  input  logic                            clk_i,
  input  logic                            rst_n,
  input  logic                            rvfi_valid,
  input  umode_pkg::priv_mode_e           rvfi_mode,
  input  logic [umode_pkg::XLEN-1:0]      rvfi_insn,
  input  logic                            rvfi_dbg_mode,
  input  logic                            trap_valid,
  input  logic                            trap_exception,
  input  logic                            trap_debug,
  input  logic [umode_pkg::CAUSE_W-1:0]   exc_cause,
  input  logic                            intr_valid,
  input  logic [umode_pkg::XLEN-1:0]      mstatus_rdata,
  input  logic [umode_pkg::XLEN-1:0]      mstatus_wdata,
  input  logic [umode_pkg::XLEN-1:0]      mstatus_wmask,
  input  logic [umode_pkg::XLEN-1:0]      dcsr_rdata,
  input  logic [umode_pkg::XLEN-1:0]      misa_rdata,
  output logic [umode_pkg::NUM_RULES-1:0] violation,
  output logic                            violation_seen,
  output umode_pkg::rule_e                first_rule
);

  umode_pkg::insn_class_e insn_class;
  logic                   illegal_insn;
  logic                   higher_exc;

  logic                   prev_valid;
  logic                   first_after_reset;
  umode_pkg::insn_class_e prev_class;
  logic                   prev_trap;
  logic                   prev_dbg_mode;
  logic                   prev_ebreaku;
  umode_pkg::priv_mode_e  prev_mode;
  umode_pkg::priv_mode_e  expected_mode;

  logic [11:0]            static_hit;
  logic [4:0]             seq_hit;

  insn_classifier u_classifier (
    .rvfi_valid     (rvfi_valid),
    .rvfi_insn      (rvfi_insn),
    .trap_valid     (trap_valid),
    .trap_exception (trap_exception),
    .trap_debug     (trap_debug),
    .exc_cause      (exc_cause),
    .insn_class     (insn_class),
    .illegal_insn   (illegal_insn),
    .higher_exc     (higher_exc)
  );

  mode_tracker u_tracker (
    .clk_i             (clk_i),
    .rst_n             (rst_n),
    .rvfi_valid        (rvfi_valid),
    .rvfi_mode         (rvfi_mode),
    .rvfi_dbg_mode     (rvfi_dbg_mode),
    .trap_valid        (trap_valid),
    .trap_exception    (trap_exception),
    .insn_class        (insn_class),
    .mstatus_rdata     (mstatus_rdata),
    .dcsr_rdata        (dcsr_rdata),
    .prev_valid        (prev_valid),
    .first_after_reset (first_after_reset),
    .prev_class        (prev_class),
    .prev_trap         (prev_trap),
    .prev_dbg_mode     (prev_dbg_mode),
    .prev_ebreaku      (prev_ebreaku),
    .prev_mode         (prev_mode),
    .expected_mode     (expected_mode)
  );

  static_rules u_static (
    .rvfi_valid     (rvfi_valid),
    .rvfi_mode      (rvfi_mode),
    .rvfi_dbg_mode  (rvfi_dbg_mode),
    .trap_valid     (trap_valid),
    .trap_exception (trap_exception),
    .exc_cause      (exc_cause),
    .insn_class     (insn_class),
    .illegal_insn   (illegal_insn),
    .higher_exc     (higher_exc),
    .rvfi_insn      (rvfi_insn),
    .mstatus_rdata  (mstatus_rdata),
    .mstatus_wdata  (mstatus_wdata),
    .mstatus_wmask  (mstatus_wmask),
    .misa_rdata     (misa_rdata),
    .static_hit     (static_hit)
  );

  sequence_rules u_sequence (
    .rvfi_valid        (rvfi_valid),
    .rvfi_mode         (rvfi_mode),
    .rvfi_dbg_mode     (rvfi_dbg_mode),
    .intr_valid        (intr_valid),
    .first_after_reset (first_after_reset),
    .prev_valid        (prev_valid),
    .prev_class        (prev_class),
    .prev_trap         (prev_trap),
    .prev_dbg_mode     (prev_dbg_mode),
    .prev_ebreaku      (prev_ebreaku),
    .prev_mode         (prev_mode),
    .expected_mode     (expected_mode),
    .seq_hit           (seq_hit)
  );

  // rule codes 12 to 16 sit above the per-retirement ones
  violation_reporter u_reporter (
    .clk_i          (clk_i),
    .rst_n          (rst_n),
    .rule_hit       ({seq_hit, static_hit}),
    .violation      (violation),
    .violation_seen (violation_seen),
    .first_rule     (first_rule)
  );

endmodule

`default_nettype wire

//--- testbench/umode_monitor_properties.sv
/*
 * Concurrent checks on the reporter outputs of the monitor.
 * Bound into every umode_monitor instance by the bind at the bottom.
 */
`default_nettype none

module umode_monitor_properties (
  input logic                            clk_i,
  input logic                            rst_n,
  input logic [umode_pkg::NUM_RULES-1:0] violation,
  input logic                            violation_seen,
  input umode_pkg::rule_e                first_rule
);

  // first edge after release still shows reset values
  reset_values_a: assert property (@(posedge clk_i)
    $rose(rst_n) |-> ((violation == '0) && !violation_seen &&
                      (first_rule == umode_pkg::RULE_MISA)))
    else $error("monitor outputs not cleared by reset");

  seen_with_pulse_a: assert property (@(posedge clk_i) disable iff (!rst_n)
    (|violation) |-> violation_seen)
    else $error("violation pulse without violation_seen");

  first_rule_stable_a: assert property (@(posedge clk_i) disable iff (!rst_n)
    (violation_seen && $past(violation_seen)) |-> $stable(first_rule))
    else $error("first_rule changed while violation_seen was high");

endmodule

bind umode_monitor umode_monitor_properties u_properties (
  .clk_i          (clk_i),
  .rst_n          (rst_n),
  .violation      (violation),
  .violation_seen (violation_seen),
  .first_rule     (first_rule)
);

`default_nettype wire

//--- testbench/tb_umode_monitor.sv
/*
 * Directed testbench for the user-mode privilege monitor.
 * Each test drives retirement beats through the retire task, one idle
 * cycle after each beat, and checks the violation pulse that follows.
 * Run the tests from the single initial block; the summary line ends the run.
 */
`default_nettype none

module tb_umode_monitor;

  logic                            clk_i;
  logic                            rst_n;
  logic                            rvfi_valid;
  umode_pkg::priv_mode_e           rvfi_mode;
  logic [umode_pkg::XLEN-1:0]      rvfi_insn;
  logic                            rvfi_dbg_mode;
  logic                            trap_valid;
  logic                            trap_exception;
  logic                            trap_debug;
  logic [umode_pkg::CAUSE_W-1:0]   exc_cause;
  logic                            intr_valid;
  logic [umode_pkg::XLEN-1:0]      mstatus_rdata;
  logic [umode_pkg::XLEN-1:0]      mstatus_wdata;
  logic [umode_pkg::XLEN-1:0]      mstatus_wmask;
  logic [umode_pkg::XLEN-1:0]      dcsr_rdata;
  logic [umode_pkg::XLEN-1:0]      misa_rdata;
  logic [umode_pkg::NUM_RULES-1:0] violation;
  logic                            violation_seen;
  umode_pkg::rule_e                first_rule;

  // beat fields that most tests leave at their defaults
  logic        beat_dbg;
  logic        beat_intr;
  logic [31:0] beat_dcsr;
  logic [31:0] wr_data;
  logic [31:0] wr_mask;
  logic [31:0] misa_value;

  logic [31:0] rng_state;
  int          error_count;
  int          test_errors;
  int          tests_run;
  int          tests_failed;

  umode_monitor UUT (
    .clk_i          (clk_i),
    .rst_n          (rst_n),
    .rvfi_valid     (rvfi_valid),
    .rvfi_mode      (rvfi_mode),
    .rvfi_insn      (rvfi_insn),
    .rvfi_dbg_mode  (rvfi_dbg_mode),
    .trap_valid     (trap_valid),
    .trap_exception (trap_exception),
    .trap_debug     (trap_debug),
    .exc_cause      (exc_cause),
    .intr_valid     (intr_valid),
    .mstatus_rdata  (mstatus_rdata),
    .mstatus_wdata  (mstatus_wdata),
    .mstatus_wmask  (mstatus_wmask),
    .dcsr_rdata     (dcsr_rdata),
    .misa_rdata     (misa_rdata),
    .violation      (violation),
    .violation_seen (violation_seen),
    .first_rule     (first_rule)
  );

  initial begin
    clk_i = 1'b0;
    forever #4 clk_i = ~clk_i;
  end

  function automatic logic [31:0] xorshift32(input logic [31:0] state);
    logic [31:0] x;
    x = state;
    x = x ^ (x << 13);
    x = x ^ (x >> 17);
    x = x ^ (x << 5);
    return x;
  endfunction

  function automatic logic [umode_pkg::NUM_RULES-1:0] rule_bit(input umode_pkg::rule_e r);
    logic [umode_pkg::NUM_RULES-1:0] v;
    v = '0;
    v[r] = 1'b1;
    return v;
  endfunction

  task automatic restore_beat_fields();
    beat_dbg   = 1'b0;
    beat_intr  = 1'b0;
    beat_dcsr  = 32'h0000_0003;
    wr_data    = 32'h0;
    wr_mask    = 32'h0;
    // RV32I with U, no S and no N
    misa_value = 32'h4010_0100;
  endtask

  // one beat, then an idle cycle; returns where violation is stable
  task automatic retire(input umode_pkg::priv_mode_e mode, input logic [31:0] insn,
                        input logic [31:0] mstatus, input logic [5:0] cause);
    @(posedge clk_i);
    rvfi_valid     <= 1'b1;
    rvfi_mode      <= mode;
    rvfi_insn      <= insn;
    rvfi_dbg_mode  <= beat_dbg;
    trap_valid     <= (cause != 6'd0);
    trap_exception <= (cause != 6'd0);
    exc_cause      <= cause;
    intr_valid     <= beat_intr;
    mstatus_rdata  <= mstatus;
    mstatus_wdata  <= wr_data;
    mstatus_wmask  <= wr_mask;
    dcsr_rdata     <= beat_dcsr;
    misa_rdata     <= misa_value;
    @(posedge clk_i);
    rvfi_valid <= 1'b0;
    @(negedge clk_i);
  endtask

  task automatic reset_dut();
    int waited;
    restore_beat_fields();
    @(posedge clk_i);
    rst_n      <= 1'b0;
    rvfi_valid <= 1'b0;
    repeat (8) @(posedge clk_i);
    rst_n <= 1'b1;
    @(negedge clk_i);
    waited = 0;
    while (((violation_seen !== 1'b0) || (violation !== '0)) && (waited < 20)) begin
      @(negedge clk_i);
      waited++;
    end
    if ((violation_seen !== 1'b0) || (violation !== '0)) begin
      $display("timeout: monitor outputs did not clear after reset");
      $display("Some tests failed");
      $finish;
    end
  endtask

  task automatic expect_pulse(input string what, input logic [umode_pkg::NUM_RULES-1:0] exp);
    if (violation !== exp) begin
      $display("** Error at time %0t: %s: violation = %05h, expected %05h",
               $time, what, violation, exp);
      error_count++;
      test_errors++;
    end
  endtask

  task automatic verify_sticky(input string what, input logic exp);
    if (violation_seen !== exp) begin
      $display("** Error at time %0t: %s: violation_seen = %b, expected %b",
               $time, what, violation_seen, exp);
      error_count++;
      test_errors++;
    end
  endtask

  task automatic compare_first_rule(input string what, input umode_pkg::rule_e exp);
    if (first_rule !== exp) begin
      $display("** Error at time %0t: %s: first_rule = %0d, expected %0d",
               $time, what, first_rule, exp);
      error_count++;
      test_errors++;
    end
  endtask

  task automatic close_test(input string name);
    tests_run++;
    if (test_errors == 0) begin
      $display("%s: ok", name);
    end else begin
      $display("%s: %0d wrong check(s)", name, test_errors);
      tests_failed++;
    end
    test_errors = 0;
  endtask

  task automatic legal_traffic();
    logic [31:0] ms;
    logic [31:0] insn;
    int          i;
    reset_dut();
    // 32'h13 is a nop
    retire(umode_pkg::MODE_M, 32'h0000_0013, 32'h0000_1800, 6'd0);
    expect_pulse("first M-mode retirement", '0);
    wr_mask = 32'h0002_0000;
    retire(umode_pkg::MODE_M, umode_pkg::MRET_INSN, 32'h0, 6'd0);
    wr_mask = 32'h0;
    expect_pulse("mret into U", '0);
    for (i = 0; i < 8; i++) begin
      // clear SD, XS, FS, MPRV, SPP; MPP is U or M
      rng_state = xorshift32(rng_state);
      ms = (rng_state & ~32'h8003_F900) | (rng_state[3] ? 32'h0000_1800 : 32'h0);
      rng_state = xorshift32(rng_state);
      insn = {rng_state[31:7], 7'b0010011};
      retire(umode_pkg::MODE_U, insn, ms, 6'd0);
      expect_pulse("legal U-mode retirement", '0);
    end
    verify_sticky("legal traffic", 1'b0);
    close_test("legal traffic");
  endtask

  task automatic static_violations();
    reset_dut();
    retire(umode_pkg::MODE_M, 32'h0000_0013, 32'h0000_1800, 6'd0);
    expect_pulse("first M-mode retirement", '0);
    misa_value = 32'h4000_0100;
    retire(umode_pkg::MODE_M, 32'h0000_0013, 32'h0000_1800, 6'd0);
    misa_value = 32'h4010_0100;
    expect_pulse("misa without U", rule_bit(umode_pkg::RULE_MISA));
    retire(umode_pkg::MODE_U, 32'h0000_0013, 32'h0002_0000, 6'd0);
    expect_pulse("U mode with MPRV set", rule_bit(umode_pkg::RULE_UMODE_MPRV));
    wr_mask = 32'h0002_0000;
    wr_data = 32'h0002_0000;
    retire(umode_pkg::MODE_M, umode_pkg::MRET_INSN, 32'h0, 6'd0);
    wr_data = 32'h0;
    wr_mask = 32'h0;
    expect_pulse("mret into U setting MPRV", rule_bit(umode_pkg::RULE_MRET_MPRV));
    verify_sticky("after static violations", 1'b1);
    compare_first_rule("first of three violations", umode_pkg::RULE_MISA);
    close_test("static rules");
  endtask

  task automatic legality_checks();
    reset_dut();
    retire(umode_pkg::MODE_M, 32'h0000_0013, 32'h0000_1800, 6'd0);
    expect_pulse("first M-mode retirement", '0);
    retire(umode_pkg::MODE_U, umode_pkg::WFI_INSN, 32'h0020_0000, 6'd0);
    expect_pulse("wfi with TW, no exception", rule_bit(umode_pkg::RULE_WFI_TW));
    retire(umode_pkg::MODE_U, umode_pkg::WFI_INSN, 32'h0020_0000, 6'd2);
    expect_pulse("wfi with TW, illegal", '0);
    retire(umode_pkg::MODE_M, 32'h0000_0013, 32'h0000_1800, 6'd0);
    expect_pulse("handler after wfi trap", '0);
    retire(umode_pkg::MODE_U, umode_pkg::URET_INSN, 32'h0, 6'd0);
    expect_pulse("uret without exception", rule_bit(umode_pkg::RULE_URET));
    // fetch integrity fault outranks the illegal instruction
    retire(umode_pkg::MODE_U, umode_pkg::URET_INSN, 32'h0, 6'd25);
    expect_pulse("uret with integrity fault", '0);
    retire(umode_pkg::MODE_M, 32'h0000_0013, 32'h0000_1800, 6'd0);
    expect_pulse("handler after uret fault", '0);
    retire(umode_pkg::MODE_U, umode_pkg::ECALL_INSN, 32'h0, 6'd8);
    expect_pulse("ecall from U", '0);
    retire(umode_pkg::MODE_M, 32'h0000_0013, 32'h0000_1800, 6'd0);
    expect_pulse("handler after ecall", '0);
    // csrrs a0, mstatus, x0
    retire(umode_pkg::MODE_U, 32'h3000_2573, 32'h0, 6'd0);
    expect_pulse("machine CSR read from U", rule_bit(umode_pkg::RULE_UCSR_ACCESS));
    close_test("legality");
  endtask

  task automatic mode_sequence();
    reset_dut();
    retire(umode_pkg::MODE_M, 32'h0000_0013, 32'h0000_1800, 6'd0);
    expect_pulse("first M-mode retirement", '0);
    wr_mask = 32'h0002_0000;
    retire(umode_pkg::MODE_M, umode_pkg::MRET_INSN, 32'h0, 6'd0);
    expect_pulse("mret into U", '0);
    retire(umode_pkg::MODE_M, 32'h0000_0013, 32'h0, 6'd0);
    expect_pulse("M after mret into U", rule_bit(umode_pkg::RULE_MRET_RESUME));
    retire(umode_pkg::MODE_M, umode_pkg::MRET_INSN, 32'h0, 6'd0);
    expect_pulse("second mret into U", '0);
    beat_intr = 1'b1;
    retire(umode_pkg::MODE_M, 32'h0000_0013, 32'h0, 6'd0);
    beat_intr = 1'b0;
    wr_mask   = 32'h0;
    expect_pulse("interrupt handler after mret", '0);
    retire(umode_pkg::MODE_U, umode_pkg::ECALL_INSN, 32'h0, 6'd8);
    expect_pulse("ecall trap", '0);
    retire(umode_pkg::MODE_U, 32'h0000_0013, 32'h0, 6'd0);
    expect_pulse("U after trap", rule_bit(umode_pkg::RULE_TRAP_MMODE));
    close_test("mode sequence");
  endtask

  task automatic debug_exits();
    reset_dut();
    retire(umode_pkg::MODE_M, 32'h0000_0013, 32'h0000_1800, 6'd0);
    expect_pulse("first M-mode retirement", '0);
    beat_dbg  = 1'b1;
    beat_dcsr = 32'h0;
    retire(umode_pkg::MODE_M, 32'h0000_0013, 32'h0000_1800, 6'd0);
    expect_pulse("debug mode with PRV=U", '0);
    beat_dbg  = 1'b0;
    beat_dcsr = 32'h0000_0003;
    retire(umode_pkg::MODE_M, 32'h0000_0013, 32'h0000_1800, 6'd0);
    expect_pulse("leave debug into M", rule_bit(umode_pkg::RULE_DRET_RESUME));
    beat_dbg  = 1'b1;
    beat_dcsr = 32'h0;
    retire(umode_pkg::MODE_M, umode_pkg::DRET_INSN, 32'h0000_1800, 6'd0);
    expect_pulse("dret with PRV=U", '0);
    beat_dbg  = 1'b0;
    retire(umode_pkg::MODE_U, 32'h0000_0013, 32'h0, 6'd0);
    expect_pulse("leave debug into U", '0);
    beat_dcsr = 32'h0000_1000;
    retire(umode_pkg::MODE_U, umode_pkg::EBREAK_INSN, 32'h0, 6'd0);
    expect_pulse("ebreak with ebreaku", '0);
    beat_dcsr = 32'h0000_0003;
    retire(umode_pkg::MODE_U, 32'h0000_0013, 32'h0, 6'd0);
    expect_pulse("no debug entry after ebreak", rule_bit(umode_pkg::RULE_EBREAKU));
    close_test("debug");
  endtask

  task automatic reset_recovery();
    verify_sticky("before reset", 1'b1);
    reset_dut();
    verify_sticky("after reset", 1'b0);
    compare_first_rule("after reset", umode_pkg::RULE_MISA);
    retire(umode_pkg::MODE_U, 32'h0000_0013, 32'h0, 6'd0);
    expect_pulse("first retirement in U", rule_bit(umode_pkg::RULE_RESET_MMODE));
    compare_first_rule("reset rule captured", umode_pkg::RULE_RESET_MMODE);
    close_test("reset");
  endtask

  initial begin
    rst_n          = 1'b0;
    rvfi_valid     = 1'b0;
    rvfi_mode      = umode_pkg::MODE_M;
    rvfi_insn      = 32'h0;
    rvfi_dbg_mode  = 1'b0;
    trap_valid     = 1'b0;
    trap_exception = 1'b0;
    trap_debug     = 1'b0;
    exc_cause      = 6'd0;
    intr_valid     = 1'b0;
    mstatus_rdata  = 32'h0;
    mstatus_wdata  = 32'h0;
    mstatus_wmask  = 32'h0;
    dcsr_rdata     = 32'h0000_0003;
    misa_rdata     = 32'h4010_0100;
    rng_state      = 32'hac84;
    error_count    = 0;
    test_errors    = 0;
    tests_run      = 0;
    tests_failed   = 0;
    restore_beat_fields();

    legal_traffic();
    static_violations();
    legality_checks();
    mode_sequence();
    debug_exits();
    reset_recovery();

    $display("tests run %0d, tests failed %0d, wrong checks %0d",
             tests_run, tests_failed, error_count);
    if (error_count == 0) begin
      $display("All tests passed");
    end else begin
      $display("Some tests failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

//--- sources.f
design/umode_pkg.sv
design/insn_classifier.sv
design/mode_tracker.sv
design/static_rules.sv
design/sequence_rules.sv
design/violation_reporter.sv
design/umode_monitor.sv
testbench/umode_monitor_properties.sv
testbench/tb_umode_monitor.sv

//--- run_sim.sh
#!/bin/sh
# Build the monitor testbench with Verilator, run it and check the result.

cd "$(dirname "$0")" || exit 1

if ! verilator --binary --timing --assert -f sources.f \
    --top-module tb_umode_monitor -o sim_umode_monitor; then
  echo "verilator build failed"
  exit 1
fi

output=$(./obj_dir/sim_umode_monitor)
status=$?
printf '%s\n' "$output"
if [ "$status" -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi

if printf '%s\n' "$output" | grep -qx "All tests passed"; then
  exit 0
fi
exit 1
